//--- source/heap_config.svh
/*
  Width macros for the heap memory unit
  Array count and array length follow from the address and index widths
*/
`ifndef HEAP_CONFIG_SVH
`define HEAP_CONFIG_SVH
`default_nettype none

`define HEAP_ADDRESS_BITS 2                          // Bits in an array number
`define HEAP_INDEX_BITS   3                          // Bits in an element index
`define HEAP_DATA_BITS    12                         // Width of one element

`define HEAP_ARRAYS       (1 << `HEAP_ADDRESS_BITS)  // Number of arrays
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS)    // Elements per array

`default_nettype wire
`endif

//--- source/heapPkg.sv
/*
  Shared types of the heap memory unit
  Widths, opcodes, error codes and controller states
*/
`include "heap_config.svh"
`default_nettype none

package heapPkg;

  typedef logic [`HEAP_ADDRESS_BITS-1:0] arrayId_t;  // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0]   index_t;    // Element index
  typedef logic [`HEAP_INDEX_BITS:0]     size_t;     // Reaches the full array length
  typedef logic [`HEAP_DATA_BITS-1:0]    data_t;     // Element value

  // --------------------------------------------------
  typedef enum logic [4:0] {
    opReset, opWrite, opRead, opSize, opPush, opPop, opAlloc, opFree,
    opAdd, opAddAfter, opSub, opSubAfter,
    opShiftLeft, opShiftRight, opNot, opNotLogical,
    opOr, opXor, opAnd
  } heapOp_t;

  typedef enum logic [2:0] {
    errNone,
    errUnallocated,                                  // Array number never handed out
    errFreed,                                        // Array handed out but freed since
    errOutOfBounds,
    errFull,
    errEmpty,
    errOutOfMemory,
    errBadOpcode
  } heapError_t;

  typedef enum logic [1:0] {
    IDLE,
    EXECUTE,                                         // Check and commit
    ACK                                              // Ack high for one cycle
  } ctrlState_t;

endpackage

`default_nettype wire

//--- source/heapInterfaces.sv
/*
  storeIf connects the controller to the element store
  allocIf connects the controller to the array allocator
*/
`timescale 1ns/100ps
`default_nettype none

interface storeIf import heapPkg::*; ();
  arrayId_t arrayId;
  index_t   index;
  logic     writeEnable;
  data_t    writeData;
  logic     sizeEnable;                              // Load newSize into the addressed array
  size_t    newSize;
  data_t    readData;                                // Element at arrayId, index
  size_t    size;                                    // Size of arrayId

  modport controller (
    output arrayId, index, writeEnable, writeData, sizeEnable, newSize,
    input  readData, size
  );
  modport store (
    input  arrayId, index, writeEnable, writeData, sizeEnable, newSize,
    output readData, size
  );
endinterface

interface allocIf import heapPkg::*; ();
  logic     allocRequest;
  logic     freeRequest;
  logic     clearAll;                                // Forget every array
  arrayId_t arrayId;                                 // Array to check or free
  arrayId_t grantedId;                               // Next array to be handed out
  logic     outOfMemory;
  logic     isAllocated;
  logic     everAllocated;                           // arrayId below the allocation counter

  modport controller (
    output allocRequest, freeRequest, clearAll, arrayId,
    input  grantedId, outOfMemory, isAllocated, everAllocated
  );
  modport allocator (
    input  allocRequest, freeRequest, clearAll, arrayId,
    output grantedId, outOfMemory, isAllocated, everAllocated
  );
endinterface

`default_nettype wire

//--- source/elementAlu.sv
/*
  Element update operations, purely combinational
*/
`timescale 1ns/100ps
`default_nettype none

module elementAlu import heapPkg::*; (
  input  heapOp_t opcode,
  input  data_t   element,                           // Current element value
  input  data_t   operand,
  output data_t   result
);

  always_comb begin
    case (opcode)
      opAdd, opAddAfter: result = element + operand;
      opSub, opSubAfter: result = element - operand;
      opShiftLeft:       result = element << operand;  // Operand is the shift amount
      opShiftRight:      result = element >> operand;
      opNot:             result = ~element;
      opNotLogical:      result = (element == '0) ? data_t'(1) : '0;
      opOr:              result = element | operand;
      opXor:             result = element ^ operand;
      opAnd:             result = element & operand;
      default:           result = element;             // Not an update
    endcase
  end

endmodule

`default_nettype wire

//--- source/arrayStore.sv
/*
  Element memory and per-array size registers
*/
`timescale 1ns/100ps
`include "heap_config.svh"
`default_nettype none

module arrayStore import heapPkg::*; (
  input logic   clock,
  storeIf.store store
);

  data_t memory [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];  // Fixed block per array
  size_t sizes  [`HEAP_ARRAYS];

  assign store.readData = memory[store.arrayId][store.index];
  assign store.size     = sizes[store.arrayId];

  // Sizes are zeroed on alloc
  always_ff @(posedge clock) begin
    if (store.writeEnable) memory[store.arrayId][store.index] <= store.writeData;
    if (store.sizeEnable) sizes[store.arrayId] <= store.newSize;
  end

endmodule

`default_nettype wire

//--- source/arrayAllocator.sv
/*
  Array allocator with freed-array stack, allocation flags and counter
*/
`timescale 1ns/100ps
`include "heap_config.svh"
`default_nettype none

module arrayAllocator import heapPkg::*; (
  input logic       clock,
  input logic       reset,
  allocIf.allocator alloc
);

  arrayId_t                    freeStack [`HEAP_ARRAYS];  // Freed array numbers
  logic [`HEAP_ADDRESS_BITS:0] freeTop;                   // Entries on the stack
  logic [`HEAP_ADDRESS_BITS:0] allocCount;                // Arrays handed out so far
  logic [`HEAP_ARRAYS-1:0]     allocated;                 // One flag per array
  arrayId_t                    stackTop;

  assign stackTop = arrayId_t'(freeTop - 1'b1);

  // Reuse freed arrays before fresh ones
  assign alloc.grantedId     = (freeTop != '0) ? freeStack[stackTop] : arrayId_t'(allocCount);
  assign alloc.outOfMemory   = (freeTop == '0) && allocCount[`HEAP_ADDRESS_BITS];
  assign alloc.isAllocated   = allocated[alloc.arrayId];
  assign alloc.everAllocated = {1'b0, alloc.arrayId} < allocCount;

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      freeTop    <= '0;
      allocCount <= '0;
      allocated  <= '0;
    end else if (alloc.clearAll) begin
      freeTop    <= '0;
      allocCount <= '0;
      allocated  <= '0;
    end else if (alloc.allocRequest) begin
      if (freeTop != '0) freeTop <= freeTop - 1'b1;
      else allocCount <= allocCount + 1'b1;
      allocated[alloc.grantedId] <= 1'b1;
    end else if (alloc.freeRequest) begin
      freeTop                  <= freeTop + 1'b1;
      allocated[alloc.arrayId] <= 1'b0;          // Flag of the freed array itself
    end
  end

  always_ff @(posedge clock) begin
    if (alloc.freeRequest) freeStack[arrayId_t'(freeTop)] <= alloc.arrayId;
  end

endmodule

`default_nettype wire

//--- source/heapController.sv
/*
  Wishbone classic slave of the heap unit
  Latches a request, checks it, then commits and acks one cycle later
*/
`timescale 1ns/100ps
`include "heap_config.svh"
`default_nettype none

module heapController import heapPkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       cyc,
  input  logic       stb,
  input  heapOp_t    opcode,
  input  arrayId_t   arrayId,
  input  index_t     index,
  input  data_t      dataIn,
  output logic       ack,
  output data_t      dataOut,
  output heapError_t errorCode,
  storeIf.controller store,
  allocIf.controller alloc,
  input  data_t      aluResult,
  output data_t      aluPrevious
);

  ctrlState_t state;
  heapOp_t    reqOpcode;
  arrayId_t   reqArray;
  index_t     reqIndex;
  data_t      reqData;
  heapError_t checkError;
  data_t      result;
  logic       commit;
  logic       arrayOp;                               // Request names an array
  logic       elementOp;                             // Request names an existing element

  // Request checks --------------------------------
  always_comb begin
    checkError = errNone;
    arrayOp    = 1'b1;
    elementOp  = 1'b0;
    case (reqOpcode)
      opReset, opAlloc: arrayOp = 1'b0;
      opWrite, opSize, opPush, opPop, opFree: elementOp = 1'b0;
      opRead, opAdd, opAddAfter, opSub, opSubAfter, opShiftLeft, opShiftRight,
      opNot, opNotLogical, opOr, opXor, opAnd: elementOp = 1'b1;
      default: begin
        arrayOp    = 1'b0;
        checkError = errBadOpcode;
      end
    endcase
    if (arrayOp) begin
      if (!alloc.everAllocated) checkError = errUnallocated;
      else if (!alloc.isAllocated) checkError = errFreed;
      else if (elementOp && size_t'(reqIndex) >= store.size) checkError = errOutOfBounds;
      else if (reqOpcode == opPush && store.size[`HEAP_INDEX_BITS]) checkError = errFull;
      else if (reqOpcode == opPop && store.size == '0) checkError = errEmpty;
    end else if (reqOpcode == opAlloc && alloc.outOfMemory) begin
      checkError = errOutOfMemory;
    end
  end

  assign commit      = (state == EXECUTE) && (checkError == errNone);
  assign aluPrevious = store.readData;               // Old element value into the ALU

  // Push writes past the end, pop reads the last element
  assign store.arrayId = (reqOpcode == opAlloc) ? alloc.grantedId : reqArray;
  assign store.index   = (reqOpcode == opPush) ? index_t'(store.size) :
                         (reqOpcode == opPop)  ? index_t'(store.size - 1'b1) : reqIndex;
  assign alloc.arrayId = reqArray;

  // Commit pulses and result select ---------------
  always_comb begin
    store.writeEnable  = 1'b0;
    store.writeData    = aluResult;
    store.sizeEnable   = 1'b0;
    store.newSize      = '0;
    alloc.allocRequest = 1'b0;
    alloc.freeRequest  = 1'b0;
    alloc.clearAll     = 1'b0;
    result             = '0;
    case (reqOpcode)
      opReset: alloc.clearAll = commit;
      opWrite: begin
        store.writeEnable = commit;
        store.writeData   = reqData;
        store.sizeEnable  = commit && (size_t'(reqIndex) >= store.size);  // Grow to cover index
        store.newSize     = size_t'(reqIndex) + 1'b1;
        result            = reqData;
      end
      opRead: result = store.readData;
      opSize: result = data_t'(store.size);
      opPush: begin
        store.writeEnable = commit;
        store.writeData   = reqData;
        store.sizeEnable  = commit;
        store.newSize     = store.size + 1'b1;
      end
      opPop: begin
        store.sizeEnable = commit;
        store.newSize    = store.size - 1'b1;
        result           = store.readData;
      end
      opAlloc: begin
        alloc.allocRequest = commit;
        store.sizeEnable   = commit;                 // New array starts empty
        result             = data_t'(alloc.grantedId);
      end
      opFree: alloc.freeRequest = commit;
      opAddAfter, opSubAfter: begin
        store.writeEnable = commit;
        result            = store.readData;          // Value before the update
      end
      default: begin
        store.writeEnable = commit;
        result            = aluResult;
      end
    endcase
  end

  // Sequencing ------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      state     <= IDLE;
      ack       <= 1'b0;
      errorCode <= errNone;
    end else begin
      ack <= 1'b0;
      case (state)
        IDLE: if (cyc && stb) state <= EXECUTE;
        EXECUTE: begin
          state     <= ACK;
          ack       <= 1'b1;
          errorCode <= checkError;
        end
        ACK: state <= IDLE;                          // stb ignored while acking
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == IDLE && cyc && stb) begin
      reqOpcode <= opcode;
      reqArray  <= arrayId;
      reqIndex  <= index;
      reqData   <= dataIn;
    end
    if (state == EXECUTE) dataOut <= (checkError == errNone) ? result : '0;
  end

endmodule

`default_nettype wire

//--- source/heapUnit.sv
/*
  Heap memory unit top level
  Controller, allocator, store and ALU behind plain Wishbone ports
*/
`timescale 1ns/100ps
`default_nettype none

module heapUnit import heapPkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       cyc,
  input  logic       stb,
  input  heapOp_t    opcode,
  input  arrayId_t   arrayId,
  input  index_t     index,
  input  data_t      dataIn,
  output logic       ack,
  output data_t      dataOut,
  output heapError_t errorCode
);

  storeIf storeBus ();
  allocIf allocBus ();

  data_t aluResult;
  data_t aluPrevious;

  heapController heapController_inst (
    .clock       (clock),
    .reset       (reset),
    .cyc         (cyc),
    .stb         (stb),
    .opcode      (opcode),
    .arrayId     (arrayId),
    .index       (index),
    .dataIn      (dataIn),
    .ack         (ack),
    .dataOut     (dataOut),
    .errorCode   (errorCode),
    .store       (storeBus.controller),
    .alloc       (allocBus.controller),
    .aluResult   (aluResult),
    .aluPrevious (aluPrevious)
  );

  arrayAllocator arrayAllocator_inst (
    .clock (clock),
    .reset (reset),
    .alloc (allocBus.allocator)
  );

  arrayStore arrayStore_inst (
    .clock (clock),
    .store (storeBus.store)
  );

  // Master holds opcode and dataIn until ack
  elementAlu elementAlu_inst (
    .opcode  (opcode),
    .element (aluPrevious),
    .operand (dataIn),
    .result  (aluResult)
  );

endmodule

`default_nettype wire

//--- sim/heapUnit_assertions.sv
/*
  Wishbone protocol assertions for the heap controller, attached with bind
*/
`timescale 1ns/100ps
`default_nettype none

module heapUnitAssertions import heapPkg::*; (
  input logic       clock,
  input logic       reset,
  input logic       cyc,
  input logic       stb,
  input logic       ack,
  input heapError_t errorCode
);

  int failures = 0;                                  // Count of failed assertions

  // Request sampled two edges before ack shows up
  ackAfterRequest: assert property (@(posedge clock) disable iff (!reset)
    $rose(ack) |-> $past(cyc && stb, 2))
    else begin
      $error("ack rose without a preceding request");
      failures++;
    end

  ackOneCycle: assert property (@(posedge clock) disable iff (!reset) ack |=> !ack)
    else begin
      $error("ack held longer than one cycle");
      failures++;
    end

  // Every 3-bit code is an enum member, so only unknown bits are illegal
  legalError: assert property (@(posedge clock) disable iff (!reset)
    !$isunknown(errorCode))
    else begin
      $error("errorCode is not a legal error value");
      failures++;
    end

endmodule

bind heapController heapUnitAssertions protocolChecks (
  .clock, .reset, .cyc, .stb, .ack, .errorCode
);

`default_nettype wire

//--- sim/heapUnitTb.sv
/*
  Testbench for the heap memory unit
  Table of requests with expected results, applied over the Wishbone port
*/
`timescale 1ns/100ps
`default_nettype none

module heapUnitTb import heapPkg::*; ();

  localparam int ANY = -1;                           // dataOut not compared

  typedef struct packed {
    heapOp_t    op;
    arrayId_t   array;
    index_t     idx;
    data_t      data;
    int         expData;
    heapError_t expError;
  } request_t;

  logic       clock;
  logic       reset;
  logic       cyc;
  logic       stb;
  heapOp_t    opcode;
  arrayId_t   arrayId;
  index_t     index;
  data_t      dataIn;
  logic       ack;
  data_t      dataOut;
  heapError_t errorCode;
  request_t   requests [$];

  heapUnit heapUnit_inst (.*);

  always #5 clock = ~clock;

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERR %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic addRow(input heapOp_t op, input int array, input int idx, input int data,
                        input int expData, input heapError_t expError);
    requests.push_back('{op, arrayId_t'(array), index_t'(idx), data_t'(data), expData,
                         expError});
  endtask

  // Write the old value, update it, read back the stored value
  task automatic addUpdate(input heapOp_t op, input int old, input int operand,
                           input int returned, input int stored);
    addRow(opWrite, 2, 1, old, old, errNone);
    addRow(op, 2, 1, operand, returned, errNone);
    addRow(opRead, 2, 1, 0, stored, errNone);
  endtask

  // Request table --------------------------------
  task automatic buildRequests();
    addRow(opRead, 0, 0, 0, ANY, errUnallocated);   // Nothing allocated yet
    for (int i = 0; i < 4; i++) addRow(opAlloc, 0, 0, 0, i, errNone);
    addRow(opAlloc, 0, 0, 0, ANY, errOutOfMemory);
    addRow(opFree, 1, 0, 0, ANY, errNone);
    addRow(opAlloc, 0, 0, 0, 1, errNone);           // Freed number comes back
    addRow(opWrite, 0, 2, 'h3c5, 'h3c5, errNone);
    addRow(opSize, 0, 0, 0, 3, errNone);
    addRow(opRead, 0, 2, 0, 'h3c5, errNone);
    addRow(opRead, 0, 5, 0, ANY, errOutOfBounds);
    for (int i = 0; i < 8; i++) addRow(opPush, 1, 0, 'h101 + i, ANY, errNone);
    addRow(opPush, 1, 0, 'h1ff, ANY, errFull);
    addRow(opSize, 1, 0, 0, 8, errNone);
    for (int i = 7; i >= 0; i--) addRow(opPop, 1, 0, 0, 'h101 + i, errNone);
    addRow(opPop, 1, 0, 0, ANY, errEmpty);
    addUpdate(opAdd,        'ha5c, 'h7f3, 'ha5c + 'h7f3, 'ha5c + 'h7f3);
    addUpdate(opAddAfter,   'ha5c, 'h7f3, 'ha5c,         'ha5c + 'h7f3);
    addUpdate(opSub,        'h35c, 'hc31, 'h35c - 'hc31, 'h35c - 'hc31);
    addUpdate(opSubAfter,   'h35c, 'hc31, 'h35c,         'h35c - 'hc31);
    addUpdate(opShiftLeft,  'ha5c, 3,     'ha5c << 3,    'ha5c << 3);
    addUpdate(opShiftRight, 'ha5c, 5,     'ha5c >> 5,    'ha5c >> 5);
    addUpdate(opNot,        'ha5c, 0,     ~'ha5c,        ~'ha5c);
    addUpdate(opNotLogical, 'ha5c, 0,     0,             0);
    addUpdate(opNotLogical, 0,     0,     1,             1);
    addUpdate(opOr,         'ha5c, 'h0f0, 'ha5c | 'h0f0, 'ha5c | 'h0f0);
    addUpdate(opXor,        'ha5c, 'h0f0, 'ha5c ^ 'h0f0, 'ha5c ^ 'h0f0);
    addUpdate(opAnd,        'ha5c, 'h0f0, 'ha5c & 'h0f0, 'ha5c & 'h0f0);
    addRow(opFree, 3, 0, 0, ANY, errNone);
    addRow(opRead, 3, 0, 0, ANY, errFreed);
    addRow(opFree, 3, 0, 0, ANY, errFreed);         // Double free
    addRow(opReset, 0, 0, 0, ANY, errNone);
    addRow(opRead, 0, 2, 0, ANY, errUnallocated);
    addRow(opAlloc, 0, 0, 0, 0, errNone);
  endtask

  // One Wishbone cycle ---------------------------
  task automatic applyRequest(input request_t row, input int number);
    int waited;
    @(posedge clock);
    cyc     <= 1'b1;
    stb     <= 1'b1;
    opcode  <= row.op;
    arrayId <= row.array;
    index   <= row.idx;
    dataIn  <= row.data;
    waited = 0;
    do begin
      @(negedge clock);                              // Outputs settled mid-cycle
      waited++;
    end while (!ack && waited < 20);
    if (!ack) begin
      $display("No ack within 20 cycles for request %0d", number);
      $display("Simulation FAILED");
      $fatal(1);
    end
    if (row.expData != ANY) checkValue("dataOut", 32'(dataOut), 32'(data_t'(row.expData)));
    checkValue("errorCode", 32'(errorCode), 32'(row.expError));
    @(posedge clock);
    cyc <= 1'b0;
    stb <= 1'b0;
  endtask

  initial begin
    clock   = 1'b0;
    reset   = 1'b0;
    cyc     = 1'b0;
    stb     = 1'b0;
    opcode  = opReset;
    arrayId = '0;
    index   = '0;
    dataIn  = '0;
    buildRequests();
    repeat (16) @(posedge clock);
    reset <= 1'b1;
    foreach (requests[i]) applyRequest(requests[i], i);
    if (heapUnit_inst.heapController_inst.protocolChecks.failures != 0) begin
      $display("Bus protocol assertions failed during the run");
      $display("Simulation FAILED");
      $fatal(1);
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- heapUnit.f
+incdir+source
source/heapPkg.sv
source/heapInterfaces.sv
source/elementAlu.sv
source/arrayStore.sv
source/arrayAllocator.sv
source/heapController.sv
source/heapUnit.sv
sim/heapUnit_assertions.sv
sim/heapUnitTb.sv

//--- Makefile
SOURCES := $(shell grep -v '^+' heapUnit.f)

.PHONY: run clean

run: obj_dir/VheapUnitTb
	out=$$(./obj_dir/VheapUnitTb); echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

obj_dir/VheapUnitTb: heapUnit.f $(SOURCES) source/heap_config.svh
	verilator --binary --timing --assert -f heapUnit.f --top-module heapUnitTb -o VheapUnitTb

clean:
	rm -rf obj_dir
